//--- hw/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Address of the first fetch after reset
`define MIPS_RESET_PC 32'h0000_0000

// syscall encoding, the core halts on it
`define MIPS_HALT_WORD 32'h0000_000c

// Register written by jal
`define MIPS_LINK_REG 5'd31

`endif

//--- hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // Primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lb    = 6'h20,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // Function field of R-type words, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll     = 6'h00,
        fn_jr      = 6'h08,
        fn_syscall = 6'h0c,
        fn_add     = 6'h20,
        fn_sub     = 6'h22,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_slt     = 6'h2a
    } funct_e;

endpackage

`default_nettype wire

//--- hw/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_sll = 3'd5,
        alu_lui = 3'd6
    } alu_op_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        wb_alu      = 2'd0,
        wb_mem_word = 2'd1,
        wb_mem_byte = 2'd2,
        wb_link     = 2'd3
    } wb_src_e;

    typedef enum logic [1:0] {
        dest_rt   = 2'd0,
        dest_rd   = 2'd1,
        dest_link = 2'd2
    } dest_sel_e;

endpackage

`default_nettype wire

//--- hw/mips_ctrl_if.sv
`default_nettype none

interface mips_ctrl_if;

    mips_ctrl_pkg::alu_op_e   alu_op;
    logic                     alu_src_imm;
    // Zero-extend the immediate, andi and ori
    logic                     imm_unsigned;
    mips_ctrl_pkg::wb_src_e   wb_src;
    mips_ctrl_pkg::dest_sel_e dest_sel;
    logic                     reg_write;
    logic                     mem_write;
    logic                     branch_eq;
    logic                     branch_ne;
    logic                     jump;
    logic                     jump_reg;

    modport decode (
        output alu_op, alu_src_imm, imm_unsigned, wb_src, dest_sel,
               reg_write, mem_write, branch_eq, branch_ne, jump, jump_reg
    );
    modport execute (input alu_op, alu_src_imm, imm_unsigned);
    modport result (input wb_src, dest_sel, reg_write);
    modport pc (
        input alu_op, alu_src_imm, imm_unsigned, branch_eq, branch_ne, jump, jump_reg
    );

endinterface

`default_nettype wire

//--- hw/mips_decoder.sv
`include "mips_settings.svh"

`default_nettype none

module mips_decoder (
    input  logic [31:0] inst,
    output logic        halted,
    mips_ctrl_if.decode ctrl
);

    mips_isa_pkg::opcode_e opcode;
    mips_isa_pkg::funct_e  funct;

    assign opcode = mips_isa_pkg::opcode_e'(inst[31:26]);
    assign funct  = mips_isa_pkg::funct_e'(inst[5:0]);
    assign halted = (inst == `MIPS_HALT_WORD);

    always_comb
    begin
        // I-type defaults, overridden per opcode
        ctrl.alu_op       = mips_ctrl_pkg::alu_add;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_unsigned = 1'b0;
        ctrl.wb_src       = mips_ctrl_pkg::wb_alu;
        ctrl.dest_sel     = mips_ctrl_pkg::dest_rt;
        ctrl.reg_write    = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.branch_eq    = 1'b0;
        ctrl.branch_ne    = 1'b0;
        ctrl.jump         = 1'b0;
        ctrl.jump_reg     = 1'b0;
        case (opcode)
            mips_isa_pkg::op_rtype:
            begin
                ctrl.alu_src_imm = 1'b0;
                ctrl.dest_sel    = mips_ctrl_pkg::dest_rd;
                ctrl.reg_write   = 1'b1;
                case (funct)
                    mips_isa_pkg::fn_add: ctrl.alu_op = mips_ctrl_pkg::alu_add;
                    mips_isa_pkg::fn_sub: ctrl.alu_op = mips_ctrl_pkg::alu_sub;
                    mips_isa_pkg::fn_and: ctrl.alu_op = mips_ctrl_pkg::alu_and;
                    mips_isa_pkg::fn_or:  ctrl.alu_op = mips_ctrl_pkg::alu_or;
                    mips_isa_pkg::fn_slt: ctrl.alu_op = mips_ctrl_pkg::alu_slt;
                    mips_isa_pkg::fn_sll: ctrl.alu_op = mips_ctrl_pkg::alu_sll;
                    mips_isa_pkg::fn_jr:
                    begin
                        ctrl.jump_reg  = 1'b1;
                        ctrl.reg_write = 1'b0;
                    end
                    // syscall and unknown functions write nothing
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            mips_isa_pkg::op_j: ctrl.jump = 1'b1;
            mips_isa_pkg::op_jal:
            begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = mips_ctrl_pkg::wb_link;
                ctrl.dest_sel  = mips_ctrl_pkg::dest_link;
            end
            mips_isa_pkg::op_beq, mips_isa_pkg::op_bne:
            begin
                ctrl.alu_op      = mips_ctrl_pkg::alu_sub;
                ctrl.alu_src_imm = 1'b0;
                ctrl.branch_eq   = (opcode == mips_isa_pkg::op_beq);
                ctrl.branch_ne   = (opcode == mips_isa_pkg::op_bne);
            end
            mips_isa_pkg::op_addi: ctrl.reg_write = 1'b1;
            mips_isa_pkg::op_slti:
            begin
                ctrl.alu_op    = mips_ctrl_pkg::alu_slt;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::op_andi, mips_isa_pkg::op_ori:
            begin
                ctrl.alu_op = (opcode == mips_isa_pkg::op_andi) ? mips_ctrl_pkg::alu_and
                                                                : mips_ctrl_pkg::alu_or;
                ctrl.imm_unsigned = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            mips_isa_pkg::op_lui:
            begin
                ctrl.alu_op    = mips_ctrl_pkg::alu_lui;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::op_lb, mips_isa_pkg::op_lw:
            begin
                ctrl.wb_src = (opcode == mips_isa_pkg::op_lb) ? mips_ctrl_pkg::wb_mem_byte
                                                              : mips_ctrl_pkg::wb_mem_word;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::op_sw: ctrl.mem_write = 1'b1;
            default: ;
        endcase
        // No state changes while parked on syscall
        if (halted)
        begin
            ctrl.reg_write = 1'b0;
            ctrl.mem_write = 1'b0;
        end
        assert (!(ctrl.reg_write && ctrl.mem_write));
    end

endmodule

`default_nettype wire

//--- hw/mips_regfile.sv
`default_nettype none

module mips_regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_num,
    input  logic [4:0]  rt_num,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic [4:0]  rd_num,
    input  logic [31:0] rd_data,
    input  logic        rd_we
);

    logic [31:0] regs [32];

    assign rs_data = regs[rs_num];
    assign rt_data = regs[rt_num];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        // $zero is never written, it keeps its reset value
        else if (rd_we && (rd_num != 5'd0))
        begin
            regs[rd_num] <= rd_data;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        ((rs_num == 5'd0) -> (rs_data == 32'd0)) && ((rt_num == 5'd0) -> (rt_data == 32'd0)));

endmodule

`default_nettype wire

//--- hw/mips_alu.sv
`default_nettype none

module mips_alu (
    input  logic [31:0]  rs_data,
    input  logic [31:0]  rt_data,
    input  logic [15:0]  imm,
    input  logic [4:0]   shamt,
    mips_ctrl_if.execute ctrl,
    output logic [31:0]  alu_result,
    output logic         zero,
    output logic [31:0]  imm_ext
);

    logic [31:0] operand_b;

    // Zero-extension only for the logical immediates
    assign imm_ext   = ctrl.imm_unsigned ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign operand_b = ctrl.alu_src_imm ? imm_ext : rt_data;

    always_comb
    begin
        case (ctrl.alu_op)
            mips_ctrl_pkg::alu_add: alu_result = rs_data + operand_b;
            mips_ctrl_pkg::alu_sub: alu_result = rs_data - operand_b;
            mips_ctrl_pkg::alu_and: alu_result = rs_data & operand_b;
            mips_ctrl_pkg::alu_or:  alu_result = rs_data | operand_b;
            mips_ctrl_pkg::alu_slt:
            begin
                alu_result = {31'd0, $signed(rs_data) < $signed(operand_b)};
            end
            // sll shifts rt, rs is unused
            mips_ctrl_pkg::alu_sll: alu_result = operand_b << shamt;
            mips_ctrl_pkg::alu_lui: alu_result = {imm, 16'h0000};
            default:                alu_result = rs_data + operand_b;
        endcase
    end

    // Branches compare through a subtract
    assign zero = (alu_result == 32'd0);

endmodule

`default_nettype wire

//--- hw/mips_result.sv
`include "mips_settings.svh"

`default_nettype none

module mips_result (
    input  logic [4:0]  inst_rt,
    input  logic [4:0]  inst_rd,
    input  logic [31:0] alu_result,
    input  logic [31:0] mem_rdata,
    input  logic [31:0] link_addr,
    mips_ctrl_if.result ctrl,
    output logic [4:0]  rd_num,
    output logic [31:0] rd_data,
    output logic        rd_we
);

    logic [7:0] load_byte;

    // Big-endian lane, byte 0 is the top of the word
    always_comb
    begin
        case (alu_result[1:0])
            2'd0:    load_byte = mem_rdata[31:24];
            2'd1:    load_byte = mem_rdata[23:16];
            2'd2:    load_byte = mem_rdata[15:8];
            default: load_byte = mem_rdata[7:0];
        endcase
    end

    always_comb
    begin
        case (ctrl.wb_src)
            mips_ctrl_pkg::wb_mem_word: rd_data = mem_rdata;
            mips_ctrl_pkg::wb_mem_byte: rd_data = {{24{load_byte[7]}}, load_byte};
            mips_ctrl_pkg::wb_link:     rd_data = link_addr;
            default:                    rd_data = alu_result;
        endcase
    end

    always_comb
    begin
        case (ctrl.dest_sel)
            mips_ctrl_pkg::dest_rd:   rd_num = inst_rd;
            mips_ctrl_pkg::dest_link: rd_num = `MIPS_LINK_REG;
            default:                  rd_num = inst_rt;
        endcase
    end

    assign rd_we = ctrl.reg_write;

endmodule

`default_nettype wire

//--- hw/mips_pc_unit.sv
`include "mips_settings.svh"

`default_nettype none

module mips_pc_unit (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        hold,
    mips_ctrl_if.pc     ctrl,
    input  logic        zero,
    input  logic [31:0] imm_ext,
    input  logic [31:0] rs_data,
    input  logic [25:0] jump_target,
    output logic [31:0] pc,
    output logic [31:0] link_addr
);

    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic        branch_taken;

    assign pc_plus4     = pc + 32'd4;
    assign link_addr    = pc_plus4;
    assign branch_taken = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

    always_comb
    begin
        if (ctrl.jump_reg)
            next_pc = rs_data;
        else if (ctrl.jump)
            next_pc = {pc_plus4[31:28], jump_target, 2'b00};
        else if (branch_taken)
            next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pc <= `MIPS_RESET_PC;
        else if (!hold)
            pc <= next_pc;
    end

    // Also catches a jr through a misaligned register
    assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/mips_core.sv
`default_nettype none

module mips_core (
    input  logic        clk,
    input  logic        arst_n,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata,
    output logic        mem_we,
    output logic        halted
);

    mips_ctrl_if ctrl ();

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_result;
    logic [31:0] imm_ext;
    logic [31:0] link_addr;
    logic [31:0] rd_data;
    logic [4:0]  rd_num;
    logic        rd_we;
    logic        zero;

    mips_decoder i_decoder (
        .inst   (inst),
        .halted (halted),
        .ctrl   (ctrl.decode)
    );

    mips_regfile i_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_num  (inst[25:21]),
        .rt_num  (inst[20:16]),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rd_num  (rd_num),
        .rd_data (rd_data),
        .rd_we   (rd_we)
    );

    mips_alu i_alu (
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .imm        (inst[15:0]),
        .shamt      (inst[10:6]),
        .ctrl       (ctrl.execute),
        .alu_result (alu_result),
        .zero       (zero),
        .imm_ext    (imm_ext)
    );

    mips_result i_result (
        .inst_rt    (inst[20:16]),
        .inst_rd    (inst[15:11]),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .link_addr  (link_addr),
        .ctrl       (ctrl.result),
        .rd_num     (rd_num),
        .rd_data    (rd_data),
        .rd_we      (rd_we)
    );

    mips_pc_unit i_pc_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .hold        (halted),
        .ctrl        (ctrl.pc),
        .zero        (zero),
        .imm_ext     (imm_ext),
        .rs_data     (rs_data),
        .jump_target (inst[25:0]),
        .pc          (inst_addr),
        .link_addr   (link_addr)
    );

    assign mem_addr  = alu_result;
    assign mem_wdata = rt_data;
    assign mem_we    = ctrl.mem_write;

endmodule

`default_nettype wire

//--- dv/mips_core_tb.sv
`include "mips_settings.svh"

`default_nettype none

module mips_core_tb;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_we;
    logic        halted;

    logic [31:0] rom [64];
    logic [31:0] ram [64] = '{default: 32'h0};
    logic [31:0] ram_init [64];
    logic [31:0] prog [$];
    integer      seed;

    mips_core i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_addr (inst_addr),
        .inst      (inst),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .halted    (halted)
    );

    // Both memories answer within the cycle
    assign inst      = rom[inst_addr[7:2]];
    assign mem_rdata = ram[mem_addr[7:2]];

    // RAM image is copied in while reset is held
    always @(posedge clk)
    begin
        if (!arst_n)
            ram <= ram_init;
        else if (mem_we)
            ram[mem_addr[7:2]] <= mem_wdata;
    end

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rtype_word(input mips_isa_pkg::funct_e fn,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
        input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] itype_word(input mips_isa_pkg::opcode_e op,
        input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype_word(input mips_isa_pkg::opcode_e op,
        input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic expect_word(input int idx, input logic [31:0] expected, input string what);
        assert (ram[idx] === expected)
        else
            stop_run($sformatf("error at time %0t: %s, RAM[%0d] = %h, expected %h",
                $time, what, idx, ram[idx], expected));
    endtask

    // Fill value differs for every word
    task automatic preset_ram();
        for (int i = 0; i < 64; i++)
            ram_init[i] = 32'hdead_0000 + i;
    endtask

    task automatic run_program();
        int cycles;
        @(negedge clk);
        arst_n = 1'b0;
        for (int i = 0; i < 64; i++)
            rom[i] = (i < prog.size()) ? prog[i] : `MIPS_HALT_WORD;
        repeat (3) @(negedge clk);
        assert (inst_addr == `MIPS_RESET_PC)
        else
            stop_run($sformatf("error at time %0t: inst_addr %h during reset", $time, inst_addr));
        arst_n = 1'b1;
        cycles = 0;
        while (!halted)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 200)
                stop_run("timeout: the core did not reach syscall within 200 cycles");
        end
    endtask

    task automatic alu_results();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] expected [11];
        for (int n = 0; n < 8; n++)
        begin
            a = $random(seed);
            b = $random(seed);
            sext = {{16{b[15]}}, b[15:0]};
            expected[0]  = a + b;
            expected[1]  = a - b;
            expected[2]  = a & b;
            expected[3]  = a | b;
            expected[4]  = {31'd0, $signed(a) < $signed(b)};
            expected[5]  = a << b[4:0];
            expected[6]  = a + sext;
            expected[7]  = a & {16'h0000, b[15:0]};
            expected[8]  = a | {16'h0000, b[15:0]};
            expected[9]  = {31'd0, $signed(a) < $signed(sext)};
            expected[10] = {a[31:16], 16'h0000};
            preset_ram();
            ram_init[0] = a;
            ram_init[1] = b;
            prog.delete();
            prog.push_back(itype_word(mips_isa_pkg::op_lw, 5'd0, 5'd1, 16'd0));
            prog.push_back(itype_word(mips_isa_pkg::op_lw, 5'd0, 5'd2, 16'd4));
            prog.push_back(rtype_word(mips_isa_pkg::fn_add, 5'd1, 5'd2, 5'd3, 5'd0));
            prog.push_back(rtype_word(mips_isa_pkg::fn_sub, 5'd1, 5'd2, 5'd4, 5'd0));
            prog.push_back(rtype_word(mips_isa_pkg::fn_and, 5'd1, 5'd2, 5'd5, 5'd0));
            prog.push_back(rtype_word(mips_isa_pkg::fn_or, 5'd1, 5'd2, 5'd6, 5'd0));
            prog.push_back(rtype_word(mips_isa_pkg::fn_slt, 5'd1, 5'd2, 5'd7, 5'd0));
            prog.push_back(rtype_word(mips_isa_pkg::fn_sll, 5'd0, 5'd1, 5'd8, b[4:0]));
            prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd1, 5'd9, b[15:0]));
            prog.push_back(itype_word(mips_isa_pkg::op_andi, 5'd1, 5'd10, b[15:0]));
            prog.push_back(itype_word(mips_isa_pkg::op_ori, 5'd1, 5'd11, b[15:0]));
            prog.push_back(itype_word(mips_isa_pkg::op_slti, 5'd1, 5'd12, b[15:0]));
            prog.push_back(itype_word(mips_isa_pkg::op_lui, 5'd0, 5'd13, a[31:16]));
            for (int k = 0; k < 11; k++)
                prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'(k + 3), 16'(8 + 4 * k)));
            prog.push_back(`MIPS_HALT_WORD);
            run_program();
            for (int k = 0; k < 11; k++)
                expect_word(k + 2, expected[k], "ALU result");
        end
    endtask

    task automatic load_paths();
        logic [7:0] lane;
        preset_ram();
        // Byte lanes alternate between top bit set and clear
        ram_init[0] = 32'h853a_f07c;
        ram_init[1] = 32'hdead_beef;
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::op_lw, 5'd0, 5'd1, 16'd4));
        prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd1, 16'd8));
        for (int k = 0; k < 4; k++)
        begin
            prog.push_back(itype_word(mips_isa_pkg::op_lb, 5'd0, 5'(k + 2), 16'(k)));
            prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'(k + 2), 16'(12 + 4 * k)));
        end
        prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd0, 16'h1234));
        prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd0, 16'd28));
        prog.push_back(`MIPS_HALT_WORD);
        run_program();
        expect_word(2, 32'hdead_beef, "lw result");
        for (int k = 0; k < 4; k++)
        begin
            lane = ram_init[0][31 - 8 * k -: 8];
            expect_word(3 + k, {{24{lane[7]}}, lane}, "lb result");
        end
        expect_word(7, 32'd0, "register 0");
    endtask

    task automatic branch_paths();
        logic [4:0]  rt;
        logic        equal;
        logic [31:0] expected [4];
        preset_ram();
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd1, 16'd5));
        prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd2, 16'd5));
        prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd3, 16'd9));
        for (int k = 0; k < 4; k++)
        begin
            rt = (k == 1 || k == 2) ? 5'd3 : 5'd2;
            equal = (rt == 5'd2);
            // beq for the first two cases, bne for the rest
            expected[k] = ((k < 2) ? equal : !equal) ? 32'h7a00 + k : 32'h0f00 + k;
            prog.push_back(itype_word((k < 2) ? mips_isa_pkg::op_beq : mips_isa_pkg::op_bne,
                5'd1, rt, 16'd2));
            prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd4, 16'(16'h0f00 + k)));
            prog.push_back(itype_word(mips_isa_pkg::op_beq, 5'd0, 5'd0, 16'd1));
            prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd4, 16'(16'h7a00 + k)));
            prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd4, 16'(4 * k)));
        end
        prog.push_back(`MIPS_HALT_WORD);
        run_program();
        for (int k = 0; k < 4; k++)
            expect_word(k, expected[k], "branch marker");
    endtask

    task automatic jump_paths();
        preset_ram();
        prog.delete();
        prog.push_back(jtype_word(mips_isa_pkg::op_jal, 26'd4));
        prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd5, 16'h0055));
        prog.push_back(jtype_word(mips_isa_pkg::op_j, 26'd6));
        prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd5, 16'd4));
        prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd31, 16'd0));
        prog.push_back(rtype_word(mips_isa_pkg::fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));
        prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd5, 16'd8));
        prog.push_back(`MIPS_HALT_WORD);
        run_program();
        expect_word(0, `MIPS_RESET_PC + 32'd4, "jal link address");
        expect_word(1, 32'hdead_0001, "store skipped by j");
        expect_word(2, 32'h0000_0055, "return through jr");
    endtask

    task automatic halt_behavior();
        preset_ram();
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd1, 16'd1));
        prog.push_back(itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd1, 16'd0));
        prog.push_back(`MIPS_HALT_WORD);
        run_program();
        for (int n = 0; n < 20; n++)
        begin
            @(negedge clk);
            assert (halted && inst_addr == 32'd8 && !mem_we)
            else
                stop_run($sformatf("error at time %0t: halt left at inst_addr %h, mem_we %b",
                    $time, inst_addr, mem_we));
        end
        expect_word(0, 32'd1, "store before syscall");
    endtask

    initial
    begin
        arst_n = 1'b0;
        seed = 73;
        preset_ram();
        for (int i = 0; i < 64; i++)
            rom[i] = `MIPS_HALT_WORD;
        alu_results();
        load_paths();
        branch_paths();
        jump_paths();
        halt_behavior();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/mips_ctrl_if.sv
hw/mips_decoder.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_result.sv
hw/mips_pc_unit.sv
hw/mips_core.sv
dv/mips_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module mips_core_tb -o mips_core_tb

# Output goes to the terminal and to grep, the search decides pass or fail
./obj_dir/mips_core_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

echo "simulation passed"
